// ==== Bender.yml ====
package:
  name: imu_states

sources:
  - files:
      - common/imu_pkg.sv
      - spi/spi_master.sv
      - imu_seq/imu_seq.sv
      - src/imu_sample_regs.sv
      - src/imu_states.sv
  - target: test
    files:
      - bench/imu_slave_model.sv
      - bench/tb_imu_states.sv

// ==== bench/imu_slave_model.sv ====
// Behavioral SPI sensor for the IMU testbench
// Mode 3 slave with a 128-byte register map, auto-increment on bursts
// Completed write frames are logged as address/value pairs
module imu_slave_model (
  input  logic ss,
  input  logic sclk,
  input  logic mosi,
  output logic miso
);

  logic [7:0] regs [0:127];
  logic [7:0] log_addr [0:31];
  logic [7:0] log_value [0:31];
  int         log_count;
  int         bad_frames;

  logic       in_frame;
  logic       is_read;
  logic [6:0] ptr;
  logic [7:0] first_byte;
  logic [7:0] rx_sr;
  logic [7:0] tx_byte;
  int         bit_cnt;
  int         byte_cnt;

  initial begin
    miso       = 1'b0;
    log_count  = 0;
    bad_frames = 0;
    in_frame   = 1'b0;
    is_read    = 1'b0;
    ptr        = '0;
    rx_sr      = '0;
    tx_byte    = '0;
    bit_cnt    = 0;
    byte_cnt   = 0;
    for (int i = 0; i < 128; i++) begin
      regs[i] = 8'h00;
    end
  end

  // Chip select low opens a frame
  always @(negedge ss) begin
    in_frame = 1'b1;
    is_read  = 1'b0;
    bit_cnt  = 0;
    byte_cnt = 0;
  end

  // Rising edge, sample MOSI
  always @(posedge sclk) begin
    if (in_frame && !ss) begin
      rx_sr   = {rx_sr[6:0], mosi};
      bit_cnt = bit_cnt + 1;
      if (bit_cnt == 8) begin
        bit_cnt = 0;
        if (byte_cnt == 0) begin
          // Address byte, bit 7 set means read
          first_byte = rx_sr;
          is_read    = rx_sr[7];
          ptr        = rx_sr[6:0];
        end else if (is_read) begin
          ptr = ptr + 7'd1;
        end else begin
          regs[ptr] = rx_sr;
          ptr       = ptr + 7'd1;
        end
        byte_cnt = byte_cnt + 1;
      end
    end
  end

  // Falling edge, next MISO bit
  always @(negedge sclk) begin
    if (in_frame && !ss) begin
      if (bit_cnt == 0) begin
        // Nothing useful during the address byte
        tx_byte = (is_read && byte_cnt > 0) ? regs[ptr] : 8'h00;
      end
      miso = tx_byte[7 - bit_cnt];
    end
  end

  // Frame end, log writes and flag odd frames
  always @(posedge ss) begin
    if (in_frame) begin
      in_frame = 1'b0;
      if (!is_read && byte_cnt == 2 && bit_cnt == 0) begin
        if (log_count < 32) begin
          log_addr[log_count]  = first_byte;
          log_value[log_count] = rx_sr;
        end
        log_count = log_count + 1;
      end else if (!(is_read && byte_cnt == 7 && bit_cnt == 0)) begin
        // Writes are 2 bytes, bursts 1 + 6
        bad_frames = bad_frames + 1;
      end
    end
  end

endmodule

// ==== bench/imu_stimulus.txt ====
// Config pairs: register address, value, in write order
// Samples: accel X Y Z, gyro X Y Z (16-bit big-endian), tick gap in cycles
6B 80
6B 00
6C 00
19 00
1A 01
1B 10
1C 08
1234 FEDC 4000 0011 8000 7FFF 0010
A5C3 0F0F 7FFE FFFF 0001 8001 0003
0000 FFFF 1357 2468 9ABC DEF0 0020
8000 7FFF C001 3FFE 00FF FF00 0001
5A5A A5A5 0102 0304 0506 0708 0008
F00D BEEF CAFE 1EE7 0BAD D00D 0014

// ==== bench/tb_imu_states.sv ====
// Testbench for the IMU front end
// Sensor model answers over SPI, the stimulus file holds the expected
// configuration writes and the register contents of each sample
module tb_imu_states;

  import imu_pkg::*;

  localparam int SPI_DIV        = 2;
  localparam int POWERUP_CYCLES = 40;
  localparam int HOLD_CYCLES    = 6;
  localparam int NUM_PAIRS      = 7;
  localparam int NUM_SAMPLES    = 6;
  localparam int STIM_WORDS     = 2 * NUM_PAIRS + 7 * NUM_SAMPLES;
  localparam int WAIT_LIMIT     = 4000;
  // Longer than the ss-high gap between two frames of one sequence
  localparam int IDLE_RUN       = HOLD_CYCLES + 4;
  // Datasheet addresses of XOUT_H
  localparam logic [6:0] ACCEL_BASE = 7'h3B;
  localparam logic [6:0] GYRO_BASE  = 7'h43;

  logic     clk;
  logic     rst;
  logic     tick;
  logic     miso;
  logic     ss;
  logic     sclk;
  logic     mosi;
  triplet_t acc;
  triplet_t gyr;
  logic     sample_valid;

  logic [15:0] stim [0:STIM_WORDS-1];
  logic [31:0] rng;
  int          errors;
  int          checks;
  int          valid_count;
  int          idle_ticks;
  int          busy_ticks;
  bit          halted;
  bit          have_held;
  triplet_t    held_acc;
  triplet_t    held_gyr;

  imu_states #(
    .SPI_DIV       (SPI_DIV),
    .POWERUP_CYCLES(POWERUP_CYCLES),
    .HOLD_CYCLES   (HOLD_CYCLES)
  ) u_dut (
    .clk         (clk),
    .rst         (rst),
    .tick        (tick),
    .miso        (miso),
    .ss          (ss),
    .sclk        (sclk),
    .mosi        (mosi),
    .acc         (acc),
    .gyr         (gyr),
    .sample_valid(sample_valid)
  );

  imu_slave_model u_slave (
    .ss  (ss),
    .sclk(sclk),
    .mosi(mosi),
    .miso(miso)
  );

  always #2 clk = ~clk;

  task automatic compare(input string name, input logic [63:0] got, input logic [63:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("** Error at %0t: %s got %h expected %h", $time, name, got, exp);
    end
  endtask

  function automatic logic [31:0] xorshift32(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  task automatic report_timeout(input string what);
    halted = 1'b1;
    errors++;
    $display("Timeout at %0t while waiting for %s", $time, what);
  endtask

  // Outputs zero until the first sample, then frozen between pulses
  always @(negedge clk) begin
    if (!rst) begin
      if (sample_valid) begin
        valid_count++;
        held_acc  = acc;
        held_gyr  = gyr;
        have_held = 1'b1;
      end else if (have_held) begin
        compare("acc", acc, held_acc);
        compare("gyr", gyr, held_gyr);
      end else begin
        compare("acc", acc, '0);
        compare("gyr", gyr, '0);
      end
    end
  end

  task automatic check_powerup();
    int n;
    n = 0;
    @(negedge clk);
    while (ss && n < WAIT_LIMIT) begin
      compare("sample_valid", sample_valid, 1'b0);
      @(negedge clk);
      n++;
    end
    if (ss) begin
      report_timeout("the first SPI frame after power-up");
    end else begin
      compare("ss high through power-up", n >= POWERUP_CYCLES, 1'b1);
    end
  endtask

  task automatic wait_config();
    int n;
    n = 0;
    while (!halted && u_slave.log_count < NUM_PAIRS && n < WAIT_LIMIT) begin
      @(negedge clk);
      n++;
    end
    if (!halted && u_slave.log_count < NUM_PAIRS) begin
      report_timeout("the configuration writes");
    end
  endtask

  task automatic wait_idle();
    int n;
    int run;
    n   = 0;
    run = 0;
    while (!halted && run < IDLE_RUN && n < WAIT_LIMIT) begin
      @(negedge clk);
      n++;
      run = ss ? run + 1 : 0;
    end
    if (!halted && run < IDLE_RUN) begin
      report_timeout("the sequencer to go idle");
    end
  endtask

  task automatic wait_read_start();
    int n;
    n = 0;
    @(negedge clk);
    while (!halted && ss && n < WAIT_LIMIT) begin
      @(negedge clk);
      n++;
    end
    if (!halted && ss) begin
      report_timeout("a burst read after the tick");
    end
  endtask

  task automatic wait_sample();
    int n;
    n = 0;
    @(negedge clk);
    while (!halted && !sample_valid && n < WAIT_LIMIT) begin
      @(negedge clk);
      n++;
    end
    if (!halted && !sample_valid) begin
      report_timeout("sample_valid after a tick");
    end
  endtask

  task automatic send_tick();
    @(posedge clk);
    tick <= 1'b1;
    @(posedge clk);
    tick <= 1'b0;
  endtask

  // Big-endian words into the sensor map, temperature bytes untouched
  task automatic load_regs(input int base);
    for (int i = 0; i < 3; i++) begin
      u_slave.regs[ACCEL_BASE + 2 * i]     = stim[base + i][15:8];
      u_slave.regs[ACCEL_BASE + 2 * i + 1] = stim[base + i][7:0];
      u_slave.regs[GYRO_BASE + 2 * i]      = stim[base + 3 + i][15:8];
      u_slave.regs[GYRO_BASE + 2 * i + 1]  = stim[base + 3 + i][7:0];
    end
  endtask

  task automatic check_config();
    for (int i = 0; i < NUM_PAIRS; i++) begin
      compare("write addr", u_slave.log_addr[i], stim[2 * i][7:0]);
      compare("write value", u_slave.log_value[i], stim[2 * i + 1][7:0]);
    end
  endtask

  task automatic run_sample(input int k);
    int base;
    int gap;
    base = 2 * NUM_PAIRS + 7 * k;
    // Reload while the previous sample is still on the outputs
    load_regs(base);
    wait_idle();
    rng = xorshift32(rng);
    gap = int'(stim[base + 6]) + int'(rng[3:0]);
    repeat (gap) @(posedge clk);
    if (!halted) begin
      send_tick();
      idle_ticks++;
      wait_read_start();
    end
    if (!halted) begin
      // Second tick lands mid-read and must be dropped
      rng = xorshift32(rng);
      repeat (rng[4:0]) @(posedge clk);
      send_tick();
      busy_ticks++;
      wait_sample();
    end
    if (!halted) begin
      compare("acc", acc, {stim[base], stim[base + 1], stim[base + 2]});
      compare("gyr", gyr, {stim[base + 3], stim[base + 4], stim[base + 5]});
    end
  endtask

  initial begin
    clk         = 1'b0;
    rst         = 1'b1;
    tick        = 1'b0;
    errors      = 0;
    checks      = 0;
    valid_count = 0;
    idle_ticks  = 0;
    busy_ticks  = 0;
    halted      = 1'b0;
    have_held   = 1'b0;
    rng         = 32'hd3bf0050;
    $readmemh("bench/imu_stimulus.txt", stim);
    if ($isunknown(stim[STIM_WORDS - 1])) begin
      errors++;
      halted = 1'b1;
      $display("Stimulus file is missing or too short");
    end
    repeat (8) @(posedge clk);
    rst <= 1'b0;
    if (!halted) begin
      check_powerup();
    end
    wait_config();
    wait_idle();
    if (!halted) begin
      check_config();
    end
    for (int k = 0; k < NUM_SAMPLES && !halted; k++) begin
      run_sample(k);
    end
    wait_idle();
    if (!halted) begin
      compare("sample_valid pulses", valid_count, idle_ticks);
      compare("write frames", u_slave.log_count, NUM_PAIRS);
      compare("bad frames", u_slave.bad_frames, 0);
    end
    $display("Checks: %0d, errors: %0d, samples: %0d, ignored ticks: %0d",
             checks, errors, valid_count, busy_ticks);
    if (errors == 0) begin
      $display("TESTBENCH PASSED");
    end else begin
      $display("TESTBENCH FAILED");
    end
    $finish;
  end

endmodule

// ==== common/imu_pkg.sv ====
// Shared types and constants for the IMU front end
// Register map, configuration table, FSM enums and bus structs
// Imported by every RTL block and by the testbench
package imu_pkg;

  // One signed sensor axis, high byte first on the wire
  typedef logic signed [15:0] axis_t;

  // X in the top bits so a left shift of big-endian bytes fills X, then Y, then Z
  typedef struct packed {
    axis_t x;
    axis_t y;
    axis_t z;
  } triplet_t;

  // Byte command into the SPI engine
  typedef struct packed {
    logic [7:0] data;
    logic       frame_end;  // release chip select after this byte
  } spi_cmd_t;

  // Byte result out of the SPI engine
  typedef struct packed {
    logic       done;
    logic [7:0] data;
  } spi_rsp_t;

  // Destination of a received byte
  typedef enum logic [1:0] {
    tag_none,
    tag_acc,
    tag_gyr
  } byte_tag_e;

  typedef enum logic [2:0] {
    st_powerup,
    st_cfg_addr,
    st_cfg_data,
    st_cfg_hold,
    st_idle,
    st_read_addr,
    st_read_byte,
    st_read_hold
  } seq_state_e;

  // MPU register addresses, 7 bit with the read flag clear
  // config_reg is CONFIG in the datasheet
  typedef enum logic [7:0] {
    smplrt_div   = 8'h19,
    config_reg   = 8'h1A,
    gyro_config  = 8'h1B,
    accel_config = 8'h1C,
    accel_xout_h = 8'h3B,
    gyro_xout_h  = 8'h43,
    pwr_mgmt_1   = 8'h6B,
    pwr_mgmt_2   = 8'h6C
  } reg_addr_e;

  typedef struct packed {
    reg_addr_e  addr;
    logic [7:0] value;
  } cfg_pair_t;

  localparam int CFG_COUNT = 7;

  // Written in this order after power-up
  localparam cfg_pair_t CFG_TABLE [CFG_COUNT] = '{
    '{addr: pwr_mgmt_1,   value: 8'h80},  // device reset
    '{addr: pwr_mgmt_1,   value: 8'h00},  // wake
    '{addr: pwr_mgmt_2,   value: 8'h00},  // all axes on
    '{addr: smplrt_div,   value: 8'h00},
    '{addr: config_reg,   value: 8'h01},  // DLPF setting 1
    '{addr: gyro_config,  value: 8'h10},  // 1000 dps
    '{addr: accel_config, value: 8'h08}   // 4 g
  };

  localparam logic [7:0] READ_FLAG  = 8'h80;
  localparam logic [7:0] DUMMY_BYTE = 8'hFF;

endpackage

// ==== imu_seq/imu_seq.sv ====
// IMU transaction sequencer
// Waits out sensor power-up, writes the configuration table once,
// then on each tick in idle burst-reads six accel and six gyro bytes
// Drives one byte command at a time into the SPI engine
module imu_seq #(
  parameter int POWERUP_CYCLES = 1000,
  parameter int HOLD_CYCLES    = 16
) (
  input  logic                clk,
  input  logic                rst,
  input  logic                tick,
  input  logic                busy,
  input  imu_pkg::spi_rsp_t   rsp,
  output logic                start,
  output imu_pkg::spi_cmd_t   cmd,
  output imu_pkg::byte_tag_e  tag,
  output logic                sample_done
);

  import imu_pkg::*;

  localparam int CNT_MAX = (POWERUP_CYCLES > HOLD_CYCLES) ? POWERUP_CYCLES : HOLD_CYCLES;
  localparam int CNT_W   = $clog2(CNT_MAX + 1);
  localparam int IDX_W   = $clog2(CFG_COUNT);

  seq_state_e       state;
  logic [CNT_W-1:0] cnt;
  logic [IDX_W-1:0] cfg_idx;
  logic [2:0]       byte_cnt;
  logic             rd_gyr;
  logic             pending;

  logic             send;
  logic [7:0]       tx_byte;
  logic             tx_fe;
  byte_tag_e        tx_tag;
  logic             issue;
  logic             acked;
  logic             hold_end;
  logic             last_byte;

  assign last_byte = (byte_cnt == 3'd5);
  assign hold_end  = (cnt == CNT_W'(HOLD_CYCLES - 1));

  // Byte to send in each transfer state
  always_comb begin
    send    = 1'b0;
    tx_byte = DUMMY_BYTE;
    tx_fe   = 1'b0;
    tx_tag  = tag_none;
    case (state)
      st_cfg_addr: begin
        send    = 1'b1;
        tx_byte = CFG_TABLE[cfg_idx].addr;
      end
      st_cfg_data: begin
        send    = 1'b1;
        tx_byte = CFG_TABLE[cfg_idx].value;
        tx_fe   = 1'b1;
      end
      st_read_addr: begin
        send    = 1'b1;
        tx_byte = READ_FLAG | (rd_gyr ? gyro_xout_h : accel_xout_h);
      end
      st_read_byte: begin
        send    = 1'b1;
        tx_fe   = last_byte;
        tx_tag  = rd_gyr ? tag_gyr : tag_acc;
      end
      default: ;
    endcase
  end

  // One outstanding byte at a time
  assign issue = send && !pending && !busy;
  assign acked = pending && rsp.done;

  always_ff @(posedge clk) begin
    if (rst) begin
      state       <= st_powerup;
      cnt         <= '0;
      cfg_idx     <= '0;
      byte_cnt    <= '0;
      rd_gyr      <= 1'b0;
      pending     <= 1'b0;
      start       <= 1'b0;
      tag         <= tag_none;
      sample_done <= 1'b0;
    end else begin
      start       <= issue;
      sample_done <= 1'b0;
      if (issue) begin
        pending <= 1'b1;
        tag     <= tx_tag;
      end else if (acked) begin
        pending <= 1'b0;
      end

      case (state)
        st_powerup: begin
          if (cnt == CNT_W'(POWERUP_CYCLES - 1)) begin
            cnt   <= '0;
            state <= st_cfg_addr;
          end else begin
            cnt <= cnt + CNT_W'(1);
          end
        end
        st_cfg_addr: if (acked) state <= st_cfg_data;
        st_cfg_data: if (acked) state <= st_cfg_hold;
        st_cfg_hold: begin
          if (hold_end) begin
            cnt <= '0;
            if (cfg_idx == IDX_W'(CFG_COUNT - 1)) begin
              state <= st_idle;
            end else begin
              cfg_idx <= cfg_idx + IDX_W'(1);
              state   <= st_cfg_addr;
            end
          end else begin
            cnt <= cnt + CNT_W'(1);
          end
        end
        // Ticks elsewhere are dropped
        st_idle: begin
          if (tick) begin
            rd_gyr <= 1'b0;
            state  <= st_read_addr;
          end
        end
        st_read_addr: begin
          if (acked) begin
            byte_cnt <= '0;
            state    <= st_read_byte;
          end
        end
        st_read_byte: begin
          if (acked) begin
            if (last_byte) begin
              state <= st_read_hold;
            end else begin
              byte_cnt <= byte_cnt + 3'd1;
            end
          end
        end
        st_read_hold: begin
          if (hold_end) begin
            cnt <= '0;
            if (rd_gyr) begin
              // Both bursts in, publish
              sample_done <= 1'b1;
              state       <= st_idle;
            end else begin
              rd_gyr <= 1'b1;
              state  <= st_read_addr;
            end
          end else begin
            cnt <= cnt + CNT_W'(1);
          end
        end
        default: state <= st_idle;
      endcase
    end
  end

  // Command byte latched with start
  always_ff @(posedge clk) begin
    if (issue) begin
      cmd.data      <= tx_byte;
      cmd.frame_end <= tx_fe;
    end
  end

endmodule

// ==== spi/spi_master.sv ====
// SPI mode-3 byte engine for the IMU link
// One start pulse moves one byte each way, MSB first
// Chip select stays low between bytes until a byte flagged frame_end completes
module spi_master #(
  parameter int SPI_DIV = 4
) (
  input  logic             clk,
  input  logic             rst,
  input  logic             start,
  input  imu_pkg::spi_cmd_t cmd,
  input  logic             miso,
  output imu_pkg::spi_rsp_t rsp,
  output logic             busy,
  output logic             ss,
  output logic             sclk,
  output logic             mosi
);

  localparam int DIV_W = (SPI_DIV > 1) ? $clog2(SPI_DIV) : 1;

  logic [DIV_W-1:0] div_cnt;
  logic [3:0]       half_cnt;
  logic             frame_end_q;
  logic             done_q;
  logic [7:0]       tx_sr;
  logic [7:0]       rx_sr;
  logic             accept;
  logic             edge_due;

  // New byte only when idle
  assign accept   = start && !busy;
  // SCLK toggles at the end of each half period
  assign edge_due = busy && (div_cnt == DIV_W'(SPI_DIV - 1));

  // Control path
  always_ff @(posedge clk) begin
    if (rst) begin
      busy        <= 1'b0;
      ss          <= 1'b1;
      sclk        <= 1'b1;
      div_cnt     <= '0;
      half_cnt    <= '0;
      frame_end_q <= 1'b0;
      done_q      <= 1'b0;
    end else begin
      done_q <= 1'b0;
      if (accept) begin
        busy        <= 1'b1;
        ss          <= 1'b0;
        sclk        <= 1'b1;
        div_cnt     <= '0;
        half_cnt    <= '0;
        frame_end_q <= cmd.frame_end;
      end else if (busy) begin
        if (edge_due) begin
          div_cnt  <= '0;
          sclk     <= ~sclk;
          half_cnt <= half_cnt + 4'd1;
          // Sixteenth edge is the last rising edge
          if (!sclk && half_cnt == 4'd15) begin
            busy   <= 1'b0;
            done_q <= 1'b1;
          end
        end else begin
          div_cnt <= div_cnt + DIV_W'(1);
        end
      end else if (done_q && frame_end_q) begin
        // End of transaction, release the sensor
        ss <= 1'b1;
      end
    end
  end

  // Shift registers
  always_ff @(posedge clk) begin
    if (accept) begin
      tx_sr <= cmd.data;
    end else if (edge_due) begin
      if (sclk) begin
        // Falling edge, next bit out
        // bit 7 is already on the line before the first fall
        if (half_cnt != 4'd0) begin
          tx_sr <= {tx_sr[6:0], 1'b0};
        end
      end else begin
        // Rising edge, sample the sensor
        rx_sr <= {rx_sr[6:0], miso};
      end
    end
  end

  assign mosi     = tx_sr[7];
  assign rsp.done = done_q;
  assign rsp.data = rx_sr;

endmodule

// ==== src/imu_sample_regs.sv ====
// Sample assembly for the IMU front end
// Received bytes shift into accel or gyro staging by tag
// Outputs change only when a full sample is done
module imu_sample_regs (
  input  logic               clk,
  input  logic               rst,
  input  imu_pkg::spi_rsp_t  rsp,
  input  imu_pkg::byte_tag_e tag,
  input  logic               sample_done,
  output imu_pkg::triplet_t  acc,
  output imu_pkg::triplet_t  gyr,
  output logic               sample_valid
);

  import imu_pkg::*;

  triplet_t acc_stage;
  triplet_t gyr_stage;

  // Big-endian bytes, XH first
  always_ff @(posedge clk) begin
    if (rsp.done) begin
      case (tag)
        tag_acc: acc_stage <= {acc_stage[39:0], rsp.data};
        tag_gyr: gyr_stage <= {gyr_stage[39:0], rsp.data};
        // Address byte responses are dropped
        default: ;
      endcase
    end
  end

  // Publish both triplets together
  always_ff @(posedge clk) begin
    if (rst) begin
      acc          <= '0;
      gyr          <= '0;
      sample_valid <= 1'b0;
    end else begin
      sample_valid <= sample_done;
      if (sample_done) begin
        acc <= acc_stage;
        gyr <= gyr_stage;
      end
    end
  end

endmodule

// ==== src/imu_states.sv ====
// IMU front end top level
// Sequencer feeds byte commands to the SPI engine, results land in the sample registers
// One acc/gyr sample per accepted tick, marked by sample_valid
module imu_states #(
  parameter int SPI_DIV        = 4,
  parameter int POWERUP_CYCLES = 1000,
  parameter int HOLD_CYCLES    = 16
) (
  input  logic              clk,
  input  logic              rst,
  input  logic              tick,
  input  logic              miso,
  output logic              ss,
  output logic              sclk,
  output logic              mosi,
  output imu_pkg::triplet_t acc,
  output imu_pkg::triplet_t gyr,
  output logic              sample_valid
);

  import imu_pkg::*;

  logic      start;
  logic      busy;
  logic      sample_done;
  spi_cmd_t  cmd;
  spi_rsp_t  rsp;
  byte_tag_e tag;

  imu_seq #(
    .POWERUP_CYCLES(POWERUP_CYCLES),
    .HOLD_CYCLES   (HOLD_CYCLES)
  ) u_seq (
    .clk        (clk),
    .rst        (rst),
    .tick       (tick),
    .busy       (busy),
    .rsp        (rsp),
    .start      (start),
    .cmd        (cmd),
    .tag        (tag),
    .sample_done(sample_done)
  );

  spi_master #(
    .SPI_DIV(SPI_DIV)
  ) u_spi (
    .clk  (clk),
    .rst  (rst),
    .start(start),
    .cmd  (cmd),
    .miso (miso),
    .rsp  (rsp),
    .busy (busy),
    .ss   (ss),
    .sclk (sclk),
    .mosi (mosi)
  );

  imu_sample_regs u_regs (
    .clk         (clk),
    .rst         (rst),
    .rsp         (rsp),
    .tag         (tag),
    .sample_done (sample_done),
    .acc         (acc),
    .gyr         (gyr),
    .sample_valid(sample_valid)
  );

endmodule

// ==== tb.f ====
common/imu_pkg.sv
spi/spi_master.sv
imu_seq/imu_seq.sv
src/imu_sample_regs.sv
src/imu_states.sv
bench/imu_slave_model.sv
bench/tb_imu_states.sv
